// ==== Bender.yml ====
package:
  name: memory_system

sources:
  - hw/mem_sys_pkg.sv
  - hw/mem_data_ram.sv
  - hw/mem_agu.sv
  - hw/mem_store_buffer.sv
  - hw/mem_load_unit.sv
  - hw/memory_system.sv
  - target: test
    files:
      - bench/tb_memory_system.sv

// ==== bench/memory_cases.txt ====
# kind st f3 base offset data dest rob exp value; st, dest and rob decimal, the rest hex
# commit lines give the pulse count in the data column; exp is st, wb, exc or -
op         1 2 00000100 00000010 12345678  0  1 st  00000000
commit     0 0 00000000 00000000 00000001  0  0 -   00000000
wait_empty 0 0 00000000 00000000 00000000  0  0 -   00000000
op         0 2 00000110 00000000 00000000  5  2 wb  12345678
op         1 2 00000200 00000000 a1b2c3f4  0  3 st  00000000
op         0 2 00000180 00000080 00000000  6  4 wb  a1b2c3f4
op         0 0 00000200 00000003 00000000  7  5 wb  ffffffa1
op         0 4 00000204 ffffffff 00000000  8  6 wb  000000a1
commit     0 0 00000000 00000000 00000001  0  0 -   00000000
wait_empty 0 0 00000000 00000000 00000000  0  0 -   00000000
op         1 0 00000111 00000000 000000ab  0  7 st  00000000
op_stall   0 2 00000110 00000000 00000000  9  8 wb  1234ab78
op         1 2 00000110 00000000 deadbeef  0  9 st  00000000
op         1 0 00000200 00000000 00000055  0 10 st  00000000
flush      0 0 00000000 00000000 00000000  0  0 -   00000000
op         0 2 00000110 00000000 00000000 10 11 wb  1234ab78
op         0 2 00000200 00000000 00000000 11 12 wb  a1b2c3f4
op         0 2 00000100 00000012 00000000 12 13 exc 00000112
op         1 1 00000300 fffffffd 00005a5a 13 14 exc 000002fd
op         0 2 000002fc 00000000 00000000 14 15 wb  00000000
op         1 2 00000300 00000000 11111111  0 16 st  00000000
op         1 2 00000300 00000004 22222222  0 17 st  00000000
op         1 2 00000300 00000008 33333333  0 18 st  00000000
op         1 2 00000300 0000000c 44444444  0 19 st  00000000
op         1 2 00000300 00000010 55555555  0 20 st  00000000
op         1 2 00000300 00000014 66666666  0 21 st  00000000
op         1 2 00000300 00000018 77777777  0 22 st  00000000
op         1 2 00000300 0000001c 88888888  0 23 st  00000000
op_stall   1 2 00000300 00000020 99999999  0 24 st  00000000
commit     0 0 00000000 00000000 00000008  0  0 -   00000000
wait_empty 0 0 00000000 00000000 00000000  0  0 -   00000000
op         0 2 00000700 00000000 00000000 15 25 wb  11111111
op         0 2 00000300 00000004 00000000 16 26 wb  22222222
op         0 2 00000300 00000008 00000000 17 27 wb  33333333
op         0 2 00000300 0000000c 00000000 18 28 wb  44444444
op         0 2 00000300 00000010 00000000 19 29 wb  55555555
op         0 2 00000300 00000014 00000000 20 30 wb  66666666
op         0 2 00000300 00000018 00000000 21 31 wb  77777777
op         0 2 00000300 0000001c 00000000 22  0 wb  88888888
op         0 2 00000300 00000020 00000000 23  1 wb  99999999

// ==== bench/tb_memory_system.sv ====
/*
 * Testbench for memory_system, driven from bench/memory_cases.txt.
 * Inputs change on the falling edge, outputs are sampled there too.
 * Only exception and store acknowledge latencies are checked exactly.
 */
`timescale 1ns/1ps

module tb_memory_system;
    import mem_sys_pkg::*;

    localparam int MAX_CASES    = 64;
    localparam int TIMEOUT      = 200;
    localparam int STALL_CYCLES = 4;
    localparam int STORE_ACK    = 2;
    localparam int EXC_ACK      = 1;

    logic              cpu_clk_i;
    logic              rst_i;
    logic              flush_i;
    logic              req_i;
    logic              ack_o;
    logic              is_store_i;
    logic [2:0]        funct3_i;
    logic [31:0]       base_i;
    logic [31:0]       offset_i;
    logic [31:0]       store_data_i;
    logic [PREG_W-1:0] dest_i;
    logic [ROB_W-1:0]  rob_i;
    logic              commit_i;
    logic              sb_empty_o;
    logic              st_done_o;
    logic [ROB_W-1:0]  st_rob_o;
    logic              wb_valid_o;
    logic [PREG_W-1:0] wb_dest_o;
    logic [31:0]       wb_data_o;
    logic [ROB_W-1:0]  wb_rob_o;
    logic              exception_o;
    logic [3:0]        exception_code_o;
    logic [ROB_W-1:0]  exception_rob_o;
    logic [31:0]       exception_addr_o;

    // Case table, one row per data line of the case file
    logic [8*12-1:0]   c_kind  [MAX_CASES];
    logic              c_store [MAX_CASES];
    logic [2:0]        c_f3    [MAX_CASES];
    logic [31:0]       c_base  [MAX_CASES];
    logic [31:0]       c_off   [MAX_CASES];
    logic [31:0]       c_data  [MAX_CASES];
    logic [PREG_W-1:0] c_dest  [MAX_CASES];
    logic [ROB_W-1:0]  c_rob   [MAX_CASES];
    logic [8*4-1:0]    c_expk  [MAX_CASES];
    logic [31:0]       c_exp   [MAX_CASES];

    int n_cases;
    int n_run;
    int errors;
    bit aborted;

    memory_system i_memory_system (.*);

    initial begin
        cpu_clk_i = 1'b0;
        forever #50 cpu_clk_i = ~cpu_clk_i;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp, input int idx);
        errors++;
        $display("error: %s = %h, expected %h (case %0d)", name, got, exp, idx);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
    endtask

    task automatic load_cases();
        int               fd;
        int               r;
        int               st;
        int               dest;
        int               rob;
        logic [8*12-1:0]  tok;
        logic [8*4-1:0]   expk;
        logic [8*128-1:0] rest;
        logic [31:0]      f3;
        logic [31:0]      base;
        logic [31:0]      off;
        logic [31:0]      data;
        logic [31:0]      exp;
        n_cases = 0;
        fd = $fopen("bench/memory_cases.txt", "r");
        if (fd == 0) begin
            report_failure("could not open bench/memory_cases.txt");
            aborted = 1'b1;
            return;
        end
        tok = '0;
        r = $fscanf(fd, "%s", tok);
        while (r == 1 && n_cases < MAX_CASES) begin
            if (tok == "#") begin
                r = $fgets(rest, fd);
            end else begin
                r = $fscanf(fd, "%d %h %h %h %h %d %d %s %h",
                            st, f3, base, off, data, dest, rob, expk, exp);
                if (r != 9) begin
                    report_failure($sformatf("malformed case line after %0d cases", n_cases));
                    aborted = 1'b1;
                    break;
                end
                c_kind[n_cases]  = tok;
                c_store[n_cases] = st[0];
                c_f3[n_cases]    = f3[2:0];
                c_base[n_cases]  = base;
                c_off[n_cases]   = off;
                c_data[n_cases]  = data;
                c_dest[n_cases]  = dest[PREG_W-1:0];
                c_rob[n_cases]   = rob[ROB_W-1:0];
                c_expk[n_cases]  = expk;
                c_exp[n_cases]   = exp;
                n_cases++;
            end
            tok = '0;
            r = $fscanf(fd, "%s", tok);
        end
        $fclose(fd);
    endtask

    task automatic pulse_commit(input int count);
        repeat (count) begin
            commit_i = 1'b1;
            @(negedge cpu_clk_i);
        end
        commit_i = 1'b0;
    endtask

    // Sampled in the first acknowledge cycle, where the completion pulses live
    task automatic check_response(input int i, input int cycles, input bit stall);
        logic [3:0] code;
        // Misaligned store is cause 6, misaligned load cause 4
        code = c_store[i] ? 4'd6 : 4'd4;
        case (c_expk[i])
            "st": begin
                if (!stall && cycles != STORE_ACK)
                    report_failure($sformatf("store on case %0d acknowledged after %0d cycles",
                                             i, cycles));
                if (st_done_o !== 1'b1)
                    report_mismatch("st_done_o", st_done_o, 1, i);
                if (st_rob_o !== c_rob[i])
                    report_mismatch("st_rob_o", st_rob_o, c_rob[i], i);
                if (exception_o !== 1'b0)
                    report_mismatch("exception_o", exception_o, 0, i);
                if (wb_valid_o !== 1'b0)
                    report_mismatch("wb_valid_o", wb_valid_o, 0, i);
            end
            "wb": begin
                if (wb_valid_o !== 1'b1)
                    report_mismatch("wb_valid_o", wb_valid_o, 1, i);
                if (wb_data_o !== c_exp[i])
                    report_mismatch("wb_data_o", wb_data_o, c_exp[i], i);
                if (wb_dest_o !== c_dest[i])
                    report_mismatch("wb_dest_o", wb_dest_o, c_dest[i], i);
                if (wb_rob_o !== c_rob[i])
                    report_mismatch("wb_rob_o", wb_rob_o, c_rob[i], i);
                if (exception_o !== 1'b0)
                    report_mismatch("exception_o", exception_o, 0, i);
            end
            "exc": begin
                if (cycles != EXC_ACK)
                    report_failure($sformatf("exception on case %0d came after %0d cycles",
                                             i, cycles));
                if (exception_o !== 1'b1)
                    report_mismatch("exception_o", exception_o, 1, i);
                if (exception_code_o !== code)
                    report_mismatch("exception_code_o", exception_code_o, code, i);
                if (exception_rob_o !== c_rob[i])
                    report_mismatch("exception_rob_o", exception_rob_o, c_rob[i], i);
                if (exception_addr_o !== c_exp[i])
                    report_mismatch("exception_addr_o", exception_addr_o, c_exp[i], i);
                if (wb_valid_o !== 1'b0)
                    report_mismatch("wb_valid_o", wb_valid_o, 0, i);
                if (st_done_o !== 1'b0)
                    report_mismatch("st_done_o", st_done_o, 0, i);
            end
            default: report_failure($sformatf("case %0d has an unknown expected kind", i));
        endcase
    endtask

    task automatic run_op(input int i, input bit stall);
        int cycles;
        is_store_i   = c_store[i];
        funct3_i     = c_f3[i];
        base_i       = c_base[i];
        offset_i     = c_off[i];
        store_data_i = c_data[i];
        dest_i       = c_dest[i];
        rob_i        = c_rob[i];
        req_i        = 1'b1;
        if (stall) begin
            // Blocked until one commit lets the oldest store drain
            repeat (STALL_CYCLES) begin
                @(negedge cpu_clk_i);
                if (ack_o !== 1'b0) begin
                    report_failure($sformatf("case %0d was acknowledged while blocked", i));
                    aborted = 1'b1;
                    return;
                end
            end
            pulse_commit(1);
        end
        cycles = 0;
        while (ack_o !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge cpu_clk_i);
            cycles++;
        end
        if (ack_o !== 1'b1) begin
            report_failure($sformatf("timeout waiting for ack_o on case %0d", i));
            aborted = 1'b1;
            return;
        end
        check_response(i, cycles, stall);
        req_i = 1'b0;
        cycles = 0;
        while (ack_o !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge cpu_clk_i);
            cycles++;
        end
        if (ack_o !== 1'b0) begin
            report_failure($sformatf("timeout waiting for ack_o to fall on case %0d", i));
            aborted = 1'b1;
        end
    endtask

    task automatic wait_drained(input int i);
        int cycles;
        cycles = 0;
        while (sb_empty_o !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge cpu_clk_i);
            cycles++;
        end
        if (sb_empty_o !== 1'b1) begin
            report_failure($sformatf("store buffer never drained on case %0d", i));
            aborted = 1'b1;
        end
    endtask

    task automatic run_case(input int i);
        case (c_kind[i])
            "op":         run_op(i, 1'b0);
            "op_stall":   run_op(i, 1'b1);
            "commit":     pulse_commit(c_data[i]);
            "wait_empty": wait_drained(i);
            "flush": begin
                flush_i = 1'b1;
                @(negedge cpu_clk_i);
                flush_i = 1'b0;
                if (sb_empty_o !== 1'b1)
                    report_mismatch("sb_empty_o", sb_empty_o, 1, i);
            end
            default: begin
                report_failure($sformatf("case %0d has an unknown kind", i));
                aborted = 1'b1;
            end
        endcase
    endtask

    initial begin
        rst_i        = 1'b1;
        flush_i      = 1'b0;
        req_i        = 1'b0;
        is_store_i   = 1'b0;
        funct3_i     = '0;
        base_i       = '0;
        offset_i     = '0;
        store_data_i = '0;
        dest_i       = '0;
        rob_i        = '0;
        commit_i     = 1'b0;
        errors       = 0;
        n_run        = 0;
        aborted      = 1'b0;
        load_cases();
        if (!aborted && n_cases == 0) begin
            report_failure("no cases found in bench/memory_cases.txt");
            aborted = 1'b1;
        end
        repeat (10) @(negedge cpu_clk_i);
        // Idle outputs while still in reset
        if (ack_o !== 1'b0)
            report_mismatch("ack_o", ack_o, 0, -1);
        if (wb_valid_o !== 1'b0)
            report_mismatch("wb_valid_o", wb_valid_o, 0, -1);
        if (st_done_o !== 1'b0)
            report_mismatch("st_done_o", st_done_o, 0, -1);
        if (exception_o !== 1'b0)
            report_mismatch("exception_o", exception_o, 0, -1);
        if (sb_empty_o !== 1'b1)
            report_mismatch("sb_empty_o", sb_empty_o, 1, -1);
        rst_i = 1'b0;
        @(negedge cpu_clk_i);
        for (int i = 0; i < n_cases && !aborted; i++) begin
            run_case(i);
            n_run++;
        end
        $display("cases run: %0d of %0d, errors: %0d", n_run, n_cases, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hw/mem_agu.sv ====
/*
 * Issue side of the memory pipe: four-phase req/ack, address generation,
 * alignment check, byte mask and routing to the store buffer or load unit.
 * Request fields must stay stable from req_i high until ack_o rises.
 */
`timescale 1ns/1ps

module mem_agu (
    input  wire logic                          cpu_clk_i,
    input  wire logic                          rst_i,
    input  wire logic                          req_i,
    output      logic                          ack_o,
    input  wire logic                          is_store_i,
    input  wire logic [2:0]                    funct3_i,
    input  wire logic [31:0]                   base_i,
    input  wire logic [31:0]                   offset_i,
    input  wire logic [31:0]                   store_data_i,
    input  wire logic [mem_sys_pkg::PREG_W-1:0] dest_i,
    input  wire logic [mem_sys_pkg::ROB_W-1:0]  rob_i,
    output      logic                          st_push,
    input  wire logic                          st_full,
    output      logic                          ld_start,
    input  wire logic                          ld_done,
    output      logic [29:0]                   op_addr,
    output      logic [3:0]                    op_mask,
    output      logic [31:0]                   op_data,
    output      logic [2:0]                    op_funct3,
    output      logic [mem_sys_pkg::PREG_W-1:0] op_dest,
    output      logic [mem_sys_pkg::ROB_W-1:0]  op_rob,
    output      logic                          st_done_o,
    output      logic [mem_sys_pkg::ROB_W-1:0]  st_rob_o,
    output      logic                          exception_o,
    output      logic [3:0]                    exception_code_o,
    output      logic [mem_sys_pkg::ROB_W-1:0]  exception_rob_o,
    output      logic [31:0]                   exception_addr_o
);
    import mem_sys_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_WAIT, S_ACK, S_HOLD} agu_state_t;

    agu_state_t  state;
    logic [31:0] eff_addr;
    logic [31:0] op_eaddr;
    logic        misalign;
    logic [3:0]  lane_mask;
    logic [31:0] lane_data;
    logic        op_store;
    logic        op_exc;
    logic        sink_done;

    assign eff_addr = base_i + offset_i;

    always_comb begin
        case (funct3_i[1:0])
            SZ_BYTE: begin
                misalign  = 1'b0;
                lane_mask = 4'b0001 << eff_addr[1:0];
                lane_data = {4{store_data_i[7:0]}};
            end
            SZ_HALF: begin
                misalign  = eff_addr[0];
                lane_mask = 4'b0011 << {eff_addr[1], 1'b0};
                lane_data = {2{store_data_i[15:0]}};
            end
            default: begin
                misalign  = |eff_addr[1:0];
                lane_mask = 4'b1111;
                lane_data = store_data_i;
            end
        endcase
    end

    // Stores go as soon as the buffer has room, loads wait for the load unit
    assign st_push   = (state == S_WAIT) && op_store && !st_full;
    assign ld_start  = (state == S_WAIT) && !op_store;
    assign sink_done = op_store ? !st_full : ld_done;

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            state    <= S_IDLE;
            op_store <= 1'b0;
            op_exc   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req_i) begin
                    op_store <= is_store_i;
                    op_exc   <= misalign;
                    state    <= misalign ? S_ACK : S_WAIT;
                end
                S_WAIT: if (sink_done) state <= S_ACK;
                S_ACK:  state <= req_i ? S_HOLD : S_IDLE;
                S_HOLD: if (!req_i) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (state == S_IDLE && req_i) begin
            op_eaddr  <= eff_addr;
            op_mask   <= lane_mask;
            op_data   <= lane_data;
            op_funct3 <= funct3_i;
            op_dest   <= dest_i;
            op_rob    <= rob_i;
        end
    end

    assign op_addr = op_eaddr[31:2];
    assign ack_o   = (state == S_ACK) || (state == S_HOLD);

    // Completion pulses last only the first acknowledge cycle
    assign st_done_o        = (state == S_ACK) && op_store && !op_exc;
    assign st_rob_o         = op_rob;
    assign exception_o      = (state == S_ACK) && op_exc;
    assign exception_code_o = op_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    assign exception_rob_o  = op_rob;
    assign exception_addr_o = op_eaddr;

    // The source must hold its fields for the whole open request
    a_req_stable: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        (req_i && !ack_o) ##1 (req_i && !ack_o) |->
            $stable({is_store_i, funct3_i, base_i, offset_i, store_data_i, dest_i, rob_i}));

endmodule

// ==== hw/mem_data_ram.sv ====
/*
 * Word-wide data RAM with a byte-masked write port and a registered read.
 * A read of the word being written in the same cycle returns the new bytes.
 * Contents start at zero and are not touched by reset.
 */
`timescale 1ns/1ps

module mem_data_ram (
    input  wire logic                           cpu_clk_i,
    input  wire logic                           we_i,
    input  wire logic [mem_sys_pkg::RAM_AW-1:0] waddr_i,
    input  wire logic [3:0]                     wmask_i,
    input  wire logic [31:0]                    wdata_i,
    input  wire logic                           re_i,
    input  wire logic [mem_sys_pkg::RAM_AW-1:0] raddr_i,
    output      logic [31:0]                    rdata_o
);
    import mem_sys_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    initial begin
        for (int w = 0; w < RAM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i && wmask_i[b]) begin
                mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
            // Write-first so a drain in this cycle is seen by the read
            if (re_i) begin
                if (we_i && wmask_i[b] && waddr_i == raddr_i) begin
                    rdata_o[8*b +: 8] <= wdata_i[8*b +: 8];
                end else begin
                    rdata_o[8*b +: 8] <= mem[raddr_i][8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== hw/mem_load_unit.sv ====
/*
 * Load sequencing: forward from the store buffer on a full hit, retry while
 * a pending store overlaps only some bytes, otherwise read the data RAM.
 * The lookup address and mask stay on the port for the whole load.
 */
`timescale 1ns/1ps

module mem_load_unit (
    input  wire logic                           cpu_clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           start_i,
    output      logic                           done_o,
    input  wire logic [29:0]                    addr_i,
    input  wire logic [3:0]                     mask_i,
    input  wire logic [2:0]                     funct3_i,
    input  wire logic [mem_sys_pkg::PREG_W-1:0] dest_i,
    input  wire logic [mem_sys_pkg::ROB_W-1:0]  rob_i,
    output      logic [29:0]                    lk_addr_o,
    output      logic [3:0]                     lk_mask_o,
    input  wire logic                           fwd_hit_i,
    input  wire logic                           fwd_partial_i,
    input  wire logic [31:0]                    fwd_data_i,
    output      logic                           ram_re_o,
    output      logic [mem_sys_pkg::RAM_AW-1:0] ram_raddr_o,
    input  wire logic [31:0]                    ram_rdata_i,
    output      logic                           wb_valid_o,
    output      logic [mem_sys_pkg::PREG_W-1:0] wb_dest_o,
    output      logic [31:0]                    wb_data_o,
    output      logic [mem_sys_pkg::ROB_W-1:0]  wb_rob_o
);
    import mem_sys_pkg::*;

    typedef enum logic [1:0] {L_IDLE, L_LOOK, L_READ} ld_state_t;

    ld_state_t         state;
    logic [29:0]       l_addr;
    logic [3:0]        l_mask;
    logic [2:0]        l_f3;
    logic [PREG_W-1:0] l_dest;
    logic [ROB_W-1:0]  l_rob;
    logic [31:0]       src_word;

    // Shift the addressed lanes down and extend per funct3
    function automatic logic [31:0] extend(input logic [31:0] word,
                                           input logic [3:0]  mask,
                                           input logic [2:0]  f3);
        logic [31:0] s;
        logic        sgn;
        if (mask[0]) s = word;
        else if (mask[1]) s = word >> 8;
        else if (mask[2]) s = word >> 16;
        else s = word >> 24;
        case (f3[1:0])
            SZ_BYTE: begin
                sgn = !f3[FN_UNSIGNED] && s[7];
                return {{24{sgn}}, s[7:0]};
            end
            SZ_HALF: begin
                sgn = !f3[FN_UNSIGNED] && s[15];
                return {{16{sgn}}, s[15:0]};
            end
            default: return s;
        endcase
    endfunction

    assign lk_addr_o   = l_addr;
    assign lk_mask_o   = l_mask;
    assign ram_re_o    = (state == L_LOOK) && !fwd_hit_i && !fwd_partial_i;
    assign ram_raddr_o = l_addr[RAM_AW-1:0];
    assign done_o      = ((state == L_LOOK) && fwd_hit_i) || (state == L_READ);
    assign src_word    = (state == L_READ) ? ram_rdata_i : fwd_data_i;

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            state      <= L_IDLE;
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= done_o;
            case (state)
                L_IDLE: if (start_i) state <= L_LOOK;
                L_LOOK: begin
                    if (fwd_hit_i) state <= L_IDLE;
                    else if (!fwd_partial_i) state <= L_READ;
                end
                L_READ: state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (state == L_IDLE && start_i) begin
            l_addr <= addr_i;
            l_mask <= mask_i;
            l_f3   <= funct3_i;
            l_dest <= dest_i;
            l_rob  <= rob_i;
        end
        if (done_o) begin
            wb_data_o <= extend(src_word, l_mask, l_f3);
            wb_dest_o <= l_dest;
            wb_rob_o  <= l_rob;
        end
    end

endmodule

// ==== hw/mem_store_buffer.sv ====
/*
 * Ordered store buffer: head, commit and tail pointers over a circular queue.
 * Committed entries drain to RAM one per cycle from the head.
 * A flush drops only the uncommitted entries. ENTRIES must be a power of two.
 */
`timescale 1ns/1ps

module mem_store_buffer #(
    parameter int ENTRIES = mem_sys_pkg::SB_ENTRIES
) (
    input  wire logic                           cpu_clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           flush_i,
    input  wire logic                           push_i,
    input  wire logic [29:0]                    addr_i,
    input  wire logic [3:0]                     mask_i,
    input  wire logic [31:0]                    data_i,
    output      logic                           full_o,
    input  wire logic                           commit_i,
    output      logic                           empty_o,
    input  wire logic [29:0]                    lk_addr_i,
    input  wire logic [3:0]                     lk_mask_i,
    output      logic                           fwd_hit_o,
    output      logic                           fwd_partial_o,
    output      logic [31:0]                    fwd_data_o,
    output      logic                           ram_we_o,
    output      logic [mem_sys_pkg::RAM_AW-1:0] ram_waddr_o,
    output      logic [3:0]                     ram_wmask_o,
    output      logic [31:0]                    ram_wdata_o
);
    import mem_sys_pkg::*;

    localparam int PW = $clog2(ENTRIES);

    logic [29:0] ent_addr [ENTRIES];
    logic [3:0]  ent_mask [ENTRIES];
    logic [31:0] ent_data [ENTRIES];

    // One extra bit tells a full queue from an empty one
    logic [PW:0]   head;
    logic [PW:0]   cmt;
    logic [PW:0]   tail;
    logic [PW:0]   count;
    logic [PW-1:0] head_idx;
    logic          do_push;
    logic          drain;

    assign count    = tail - head;
    assign head_idx = head[PW-1:0];
    assign full_o   = (count == (PW+1)'(ENTRIES));
    assign empty_o  = (head == tail);
    assign do_push  = push_i && !full_o && !flush_i;
    assign drain    = (head != cmt);

    always_ff @(posedge cpu_clk_i) begin
        if (rst_i) begin
            head <= '0;
            cmt  <= '0;
            tail <= '0;
        end else begin
            if (drain) head <= head + 1'b1;
            if (commit_i) cmt <= cmt + 1'b1;
            if (flush_i) begin
                tail <= cmt + (PW+1)'(commit_i);
            end else if (do_push) begin
                tail <= tail + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (do_push) begin
            ent_addr[tail[PW-1:0]] <= addr_i;
            ent_mask[tail[PW-1:0]] <= mask_i;
            ent_data[tail[PW-1:0]] <= data_i;
        end
    end

    assign ram_we_o    = drain;
    assign ram_waddr_o = ent_addr[head_idx][RAM_AW-1:0];
    assign ram_wmask_o = ent_mask[head_idx];
    assign ram_wdata_o = ent_data[head_idx];

    // Walk from oldest to youngest so the youngest overlapping store wins
    always_comb begin : lookup
        logic [PW-1:0] slot;
        fwd_hit_o     = 1'b0;
        fwd_partial_o = 1'b0;
        fwd_data_o    = '0;
        slot          = head_idx;
        for (int i = 0; i < ENTRIES; i++) begin
            slot = head_idx + PW'(i);
            if ((PW+1)'(i) < count && ent_addr[slot] == lk_addr_i &&
                |(ent_mask[slot] & lk_mask_i)) begin
                fwd_hit_o     = ((ent_mask[slot] & lk_mask_i) == lk_mask_i);
                fwd_partial_o = !fwd_hit_o;
                fwd_data_o    = ent_data[slot];
            end
        end
    end

    a_no_push_full: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        push_i |-> !full_o);

    a_commit_pending: assert property (@(posedge cpu_clk_i) disable iff (rst_i)
        commit_i |-> (cmt != tail));

endmodule

// ==== hw/mem_sys_pkg.sv ====
/*
 * Shared constants for the reduced load/store subsystem.
 * Width codes follow RISC-V funct3 bits 1:0; bit 2 selects zero extension.
 * The data RAM is 256 words, so effective addresses wrap modulo 1 KiB.
 */
package mem_sys_pkg;

    // Store buffer depth, must be a power of two and at least 2
    localparam int SB_ENTRIES = 8;

    // Tightly coupled data RAM geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    // Tag widths seen at the core interface
    localparam int ROB_W  = 5;
    localparam int PREG_W = 6;

    // Access width, funct3[1:0]
    localparam logic [1:0] SZ_BYTE = 2'b00;
    localparam logic [1:0] SZ_HALF = 2'b01;
    localparam logic [1:0] SZ_WORD = 2'b10;

    // funct3 bit that marks LBU and LHU
    localparam int FN_UNSIGNED = 2;

    // Exception causes, as in mcause
    localparam logic [3:0] EXC_LD_MISALIGN = 4'd4;
    localparam logic [3:0] EXC_ST_MISALIGN = 4'd6;

endpackage

// ==== hw/memory_system.sv ====
/*
 * Reduced load/store subsystem: AGU, store buffer, load unit and data RAM.
 * One operation is open at a time. flush_i may only be raised between
 * requests. Addresses wrap modulo the 1 KiB data RAM.
 */
`timescale 1ns/1ps

module memory_system (
    input  wire logic                           cpu_clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           flush_i,
    input  wire logic                           req_i,
    output wire logic                           ack_o,
    input  wire logic                           is_store_i,
    input  wire logic [2:0]                     funct3_i,
    input  wire logic [31:0]                    base_i,
    input  wire logic [31:0]                    offset_i,
    input  wire logic [31:0]                    store_data_i,
    input  wire logic [mem_sys_pkg::PREG_W-1:0] dest_i,
    input  wire logic [mem_sys_pkg::ROB_W-1:0]  rob_i,
    input  wire logic                           commit_i,
    output wire logic                           sb_empty_o,
    output wire logic                           st_done_o,
    output wire logic [mem_sys_pkg::ROB_W-1:0]  st_rob_o,
    output wire logic                           wb_valid_o,
    output wire logic [mem_sys_pkg::PREG_W-1:0] wb_dest_o,
    output wire logic [31:0]                    wb_data_o,
    output wire logic [mem_sys_pkg::ROB_W-1:0]  wb_rob_o,
    output wire logic                           exception_o,
    output wire logic [3:0]                     exception_code_o,
    output wire logic [mem_sys_pkg::ROB_W-1:0]  exception_rob_o,
    output wire logic [31:0]                    exception_addr_o
);
    import mem_sys_pkg::*;

    wire logic              st_push;
    wire logic              st_full;
    wire logic              ld_start;
    wire logic              ld_done;
    wire logic [29:0]       op_addr;
    wire logic [3:0]        op_mask;
    wire logic [31:0]       op_data;
    wire logic [2:0]        op_funct3;
    wire logic [PREG_W-1:0] op_dest;
    wire logic [ROB_W-1:0]  op_rob;
    wire logic [29:0]       lk_addr;
    wire logic [3:0]        lk_mask;
    wire logic              fwd_hit;
    wire logic              fwd_partial;
    wire logic [31:0]       fwd_data;
    wire logic              ram_we;
    wire logic [RAM_AW-1:0] ram_waddr;
    wire logic [3:0]        ram_wmask;
    wire logic [31:0]       ram_wdata;
    wire logic              ram_re;
    wire logic [RAM_AW-1:0] ram_raddr;
    wire logic [31:0]       ram_rdata;

    mem_agu i_mem_agu (
        .cpu_clk_i, .rst_i, .req_i, .ack_o, .is_store_i, .funct3_i,
        .base_i, .offset_i, .store_data_i, .dest_i, .rob_i,
        .st_push, .st_full, .ld_start, .ld_done,
        .op_addr, .op_mask, .op_data, .op_funct3, .op_dest, .op_rob,
        .st_done_o, .st_rob_o, .exception_o, .exception_code_o,
        .exception_rob_o, .exception_addr_o
    );

    mem_store_buffer #(.ENTRIES(SB_ENTRIES)) i_mem_store_buffer (
        .cpu_clk_i, .rst_i, .flush_i,
        .push_i(st_push), .addr_i(op_addr), .mask_i(op_mask), .data_i(op_data),
        .full_o(st_full), .commit_i, .empty_o(sb_empty_o),
        .lk_addr_i(lk_addr), .lk_mask_i(lk_mask),
        .fwd_hit_o(fwd_hit), .fwd_partial_o(fwd_partial), .fwd_data_o(fwd_data),
        .ram_we_o(ram_we), .ram_waddr_o(ram_waddr),
        .ram_wmask_o(ram_wmask), .ram_wdata_o(ram_wdata)
    );

    mem_load_unit i_mem_load_unit (
        .cpu_clk_i, .rst_i, .start_i(ld_start), .done_o(ld_done),
        .addr_i(op_addr), .mask_i(op_mask), .funct3_i(op_funct3),
        .dest_i(op_dest), .rob_i(op_rob),
        .lk_addr_o(lk_addr), .lk_mask_o(lk_mask),
        .fwd_hit_i(fwd_hit), .fwd_partial_i(fwd_partial), .fwd_data_i(fwd_data),
        .ram_re_o(ram_re), .ram_raddr_o(ram_raddr), .ram_rdata_i(ram_rdata),
        .wb_valid_o, .wb_dest_o, .wb_data_o, .wb_rob_o
    );

    mem_data_ram i_mem_data_ram (
        .cpu_clk_i,
        .we_i(ram_we), .waddr_i(ram_waddr), .wmask_i(ram_wmask), .wdata_i(ram_wdata),
        .re_i(ram_re), .raddr_i(ram_raddr), .rdata_o(ram_rdata)
    );

endmodule

// ==== memory_system.f ====
hw/mem_sys_pkg.sv
hw/mem_data_ram.sv
hw/mem_agu.sv
hw/mem_store_buffer.sv
hw/mem_load_unit.sv
hw/memory_system.sv
bench/tb_memory_system.sv
